/* src/coreTypesPkg.sv */
package coreTypesPkg;

    localparam int regWidth = 32;
    localparam int regIndexWidth = 4;

    localparam logic [regWidth-1:0] dataAreaStart = 32'd8192;
    localparam logic [regWidth-1:0] stackTop = {regWidth{1'b1}};

    localparam logic [regIndexWidth-1:0] lrIndex = 4'd13;
    localparam logic [regIndexWidth-1:0] spIndex = 4'd14;   // Banked stack pointer
    localparam logic [regIndexWidth-1:0] pcIndex = 4'd15;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opMovi,
        opStore,
        opPush,
        opSvc,
        opEret
    } opcodeT;

    typedef struct packed {
        opcodeT opcode;
        logic [regIndexWidth-1:0] rd;
        logic [regIndexWidth-1:0] rs1;
        logic [regIndexWidth-1:0] rs2;
        logic [15:0] imm;
    } instrT;

    typedef struct packed {
        opcodeT opcode;
        logic [regIndexWidth-1:0] rd;
        logic [regIndexWidth-1:0] rs1;
        logic [regIndexWidth-1:0] rs2;
        logic [regWidth-1:0] imm;   // Zero extended
    } decodedT;

    typedef struct packed {
        logic [regWidth-1:0] addr;
        logic [regWidth-1:0] data;
    } storeMsgT;

    typedef enum logic {idle, waitStore} execStateT;

endpackage

/* src/instrPort.sv */
`timescale 1ns/1ps

module instrPort (
    input  logic clock,
    input  logic reset,
    input  logic instrReq,
    input  coreTypesPkg::instrT instrWord,
    output logic instrAck,
    output logic decValid,
    output coreTypesPkg::decodedT decoded,
    input  logic decTake
);
    import coreTypesPkg::*;

    logic acceptWord;

    // New request only once the previous ack has dropped
    assign acceptWord = instrReq && !instrAck && !decValid;

    always_ff @(posedge clock) begin
        if (reset) begin
            instrAck <= 1'b0;
            decValid <= 1'b0;
        end else begin
            if (instrAck && !instrReq) begin
                instrAck <= 1'b0;   // Phase four
            end else if (acceptWord) begin
                instrAck <= 1'b1;
            end

            if (acceptWord) begin
                decValid <= 1'b1;
            end else if (decTake) begin
                decValid <= 1'b0;   // Buffer drained
            end
        end
    end

    // Decoded word buffer
    always_ff @(posedge clock) begin
        if (acceptWord) begin
            decoded.opcode <= instrWord.opcode;
            decoded.rd     <= instrWord.rd;
            decoded.rs1    <= instrWord.rs1;
            decoded.rs2    <= instrWord.rs2;
            decoded.imm    <= regWidth'(instrWord.imm);
        end
    end

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  coreTypesPkg::opcodeT op,
    input  logic [coreTypesPkg::regWidth-1:0] a,
    input  logic [coreTypesPkg::regWidth-1:0] b,
    input  logic [coreTypesPkg::regWidth-1:0] imm,
    output logic [coreTypesPkg::regWidth-1:0] result
);
    import coreTypesPkg::*;

    always_comb begin
        case (op)
            opAdd:   result = a + b;
            opSub:   result = a - b;
            opAnd:   result = a & b;
            opOr:    result = a | b;
            opXor:   result = a ^ b;
            opMovi:  result = imm;
            opStore: result = a + imm;   // Store address
            default: result = '0;
        endcase
    end

endmodule

/* src/regBank.sv */
`timescale 1ns/1ps

module regBank (
    input  logic clock,
    input  logic reset,
    input  logic privileged,
    input  logic [coreTypesPkg::regIndexWidth-1:0] idxA,
    input  logic [coreTypesPkg::regIndexWidth-1:0] idxB,
    input  logic [coreTypesPkg::regIndexWidth-1:0] idxD,
    input  logic writeEnable,
    input  logic [coreTypesPkg::regWidth-1:0] writeData,
    input  logic svcEnter,
    input  logic pcAdvance,
    input  logic spDecrement,
    output logic [coreTypesPkg::regWidth-1:0] readA,
    output logic [coreTypesPkg::regWidth-1:0] readB
);
    import coreTypesPkg::*;

    logic [regWidth-1:0] gpr [0:lrIndex];   // r0 to r13
    logic [regWidth-1:0] userSp;
    logic [regWidth-1:0] privSp;
    logic [regWidth-1:0] pc;
    logic [regWidth-1:0] curSp;
    logic destIsGpr;

    assign curSp = privileged ? privSp : userSp;
    assign destIsGpr = idxD < spIndex;   // r14 and r15 are read only

    function automatic logic [regWidth-1:0] readReg(input logic [regIndexWidth-1:0] idx);
        if (idx == spIndex) begin
            return curSp;
        end else if (idx == pcIndex) begin
            return pc;
        end
        return gpr[idx];
    endfunction

    always_comb begin
        readA = readReg(idxA);
        readB = readReg(idxB);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            gpr[0] <= dataAreaStart;
            userSp <= stackTop;
            privSp <= stackTop;
            pc     <= '0;
        end else begin
            if (writeEnable && destIsGpr) begin
                gpr[idxD] <= writeData;
            end

            if (svcEnter) begin
                gpr[lrIndex] <= pc + 1'b1;   // Return point
                privSp       <= stackTop;
            end else if (spDecrement) begin
                if (privileged) begin
                    privSp <= privSp - 1'b1;
                end else begin
                    userSp <= userSp - 1'b1;
                end
            end

            if (pcAdvance) begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

/* src/execControl.sv */
`timescale 1ns/1ps

module execControl (
    input  logic clock,
    input  logic reset,
    input  logic decValid,
    input  coreTypesPkg::decodedT decoded,
    output logic decTake,
    output logic [coreTypesPkg::regIndexWidth-1:0] idxA,
    output logic [coreTypesPkg::regIndexWidth-1:0] idxB,
    output logic [coreTypesPkg::regIndexWidth-1:0] idxD,
    output logic writeEnable,
    output logic [coreTypesPkg::regWidth-1:0] writeData,
    output logic svcEnter,
    output logic pcAdvance,
    output logic spDecrement,
    output logic privileged,
    input  logic [coreTypesPkg::regWidth-1:0] aluResult,
    input  logic [coreTypesPkg::regWidth-1:0] readA,
    input  logic [coreTypesPkg::regWidth-1:0] readB,
    output logic sendStart,
    output coreTypesPkg::storeMsgT sendMsg,
    input  logic sendBusy
);
    import coreTypesPkg::*;

    execStateT state;
    logic take;

    assign decTake = (state == idle) && !sendBusy;
    assign take = decTake && decValid;

    // Push reads the current stack pointer through port B
    assign idxA = decoded.rs1;
    assign idxB = (decoded.opcode == opPush) ? spIndex : decoded.rs2;
    assign idxD = decoded.rd;
    assign writeData = aluResult;
    assign pcAdvance = take;   // Every taken instruction retires

    always_comb begin
        writeEnable = 1'b0;
        svcEnter    = 1'b0;
        spDecrement = 1'b0;
        sendStart   = 1'b0;
        sendMsg     = '{addr: aluResult, data: readB};
        case (decoded.opcode)
            opAdd, opSub, opAnd, opOr, opXor, opMovi: begin
                writeEnable = take;
            end
            opStore: begin
                sendStart = take;
            end
            opPush: begin
                sendStart   = take;
                spDecrement = take;
                sendMsg     = '{addr: readB, data: readA};
            end
            opSvc: begin
                svcEnter = take;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= idle;
            privileged <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (sendStart) begin
                        state <= waitStore;
                    end
                end
                waitStore: begin
                    if (!sendBusy) begin
                        state <= idle;   // Store handshake finished
                    end
                end
                default: state <= idle;
            endcase

            if (take && decoded.opcode == opSvc) begin
                privileged <= 1'b1;
            end else if (take && decoded.opcode == opEret) begin
                privileged <= 1'b0;
            end
        end
    end

endmodule

/* src/storePort.sv */
`timescale 1ns/1ps

module storePort (
    input  logic clock,
    input  logic reset,
    input  logic sendStart,
    input  coreTypesPkg::storeMsgT sendMsg,
    output logic sendBusy,
    output logic storeReq,
    output coreTypesPkg::storeMsgT storeMsg,
    input  logic storeAck
);
    import coreTypesPkg::*;

    always_ff @(posedge clock) begin
        if (reset) begin
            storeReq <= 1'b0;
            sendBusy <= 1'b0;
        end else begin
            if (sendStart) begin
                storeReq <= 1'b1;
                sendBusy <= 1'b1;
            end else if (storeReq && storeAck) begin
                storeReq <= 1'b0;   // Ack seen
            end else if (sendBusy && !storeReq && !storeAck) begin
                sendBusy <= 1'b0;   // Ack returned low
            end
        end
    end

    // Held stable through the handshake
    always_ff @(posedge clock) begin
        if (sendStart) begin
            storeMsg <= sendMsg;
        end
    end

endmodule

/* src/execCore.sv */
`timescale 1ns/1ps

module execCore (
    input  logic clock,
    input  logic reset,
    input  logic instrReq,
    input  coreTypesPkg::instrT instrWord,
    output logic instrAck,
    output logic storeReq,
    output coreTypesPkg::storeMsgT storeMsg,
    input  logic storeAck
);
    import coreTypesPkg::*;

    logic decValid;
    logic decTake;
    decodedT decoded;
    logic [regIndexWidth-1:0] idxA;
    logic [regIndexWidth-1:0] idxB;
    logic [regIndexWidth-1:0] idxD;
    logic writeEnable;
    logic [regWidth-1:0] writeData;
    logic svcEnter;
    logic pcAdvance;
    logic spDecrement;
    logic privileged;
    logic [regWidth-1:0] readA;
    logic [regWidth-1:0] readB;
    logic [regWidth-1:0] aluResult;
    logic sendStart;
    logic sendBusy;
    storeMsgT sendMsg;

    instrPort instrPort0 (
        .clock(clock),
        .reset(reset),
        .instrReq(instrReq),
        .instrWord(instrWord),
        .instrAck(instrAck),
        .decValid(decValid),
        .decoded(decoded),
        .decTake(decTake)
    );

    execControl execControl0 (
        .clock(clock),
        .reset(reset),
        .decValid(decValid),
        .decoded(decoded),
        .decTake(decTake),
        .idxA(idxA),
        .idxB(idxB),
        .idxD(idxD),
        .writeEnable(writeEnable),
        .writeData(writeData),
        .svcEnter(svcEnter),
        .pcAdvance(pcAdvance),
        .spDecrement(spDecrement),
        .privileged(privileged),
        .aluResult(aluResult),
        .readA(readA),
        .readB(readB),
        .sendStart(sendStart),
        .sendMsg(sendMsg),
        .sendBusy(sendBusy)
    );

    aluUnit aluUnit0 (
        .op(decoded.opcode),
        .a(readA),
        .b(readB),
        .imm(decoded.imm),
        .result(aluResult)
    );

    regBank regBank0 (
        .clock(clock),
        .reset(reset),
        .privileged(privileged),
        .idxA(idxA),
        .idxB(idxB),
        .idxD(idxD),
        .writeEnable(writeEnable),
        .writeData(writeData),
        .svcEnter(svcEnter),
        .pcAdvance(pcAdvance),
        .spDecrement(spDecrement),
        .readA(readA),
        .readB(readB)
    );

    storePort storePort0 (
        .clock(clock),
        .reset(reset),
        .sendStart(sendStart),
        .sendMsg(sendMsg),
        .sendBusy(sendBusy),
        .storeReq(storeReq),
        .storeMsg(storeMsg),
        .storeAck(storeAck)
    );

endmodule

/* tb/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;   // 8 ns period
        end
    end

endmodule

/* tb/execCore_props.sv */
`timescale 1ns/1ps

module execCore_props (
    input logic clock,
    input logic reset,
    input logic instrReq,
    input logic instrAck,
    input logic storeReq,
    input logic storeAck,
    input coreTypesPkg::storeMsgT storeMsg
);

    // Sender side of the store handshake
    storeReqHolds: assert property (
        @(posedge clock) disable iff (reset)
        storeReq && !storeAck |=> storeReq && $stable(storeMsg)
    ) else $error("storeReq dropped or storeMsg changed before storeAck");

    // Receiver side of the instruction handshake
    instrAckHolds: assert property (
        @(posedge clock) disable iff (reset)
        instrAck && instrReq |=> instrAck
    ) else $error("instrAck fell while instrReq was still high");

    quietAfterReset: assert property (
        @(posedge clock)
        reset |=> !storeReq && !instrAck
    ) else $error("storeReq or instrAck high in the cycle after reset");

endmodule

/* tb/execCore_tb.sv */
`timescale 1ns/1ps

module execCore_tb;
    import coreTypesPkg::*;

    logic clock;
    logic reset;
    logic instrReq;
    instrT instrWord;
    logic instrAck;
    logic storeReq;
    storeMsgT storeMsg;
    logic storeAck;

    logic [regWidth-1:0] modelGpr [0:lrIndex];
    logic [regWidth-1:0] modelUserSp;
    logic [regWidth-1:0] modelPrivSp;
    logic [regWidth-1:0] modelPc;
    logic modelPriv;
    storeMsgT expMsgs[$];
    string expNames[$];
    string testName = "reset";
    int issuedCount = 0;
    int cycleCount = 0;

    tbClock clockGen (.clock(clock));

    execCore dut0 (
        .clock(clock),
        .reset(reset),
        .instrReq(instrReq),
        .instrWord(instrWord),
        .instrAck(instrAck),
        .storeReq(storeReq),
        .storeMsg(storeMsg),
        .storeAck(storeAck)
    );

    bind execCore execCore_props props0 (
        .clock(clock),
        .reset(reset),
        .instrReq(instrReq),
        .instrAck(instrAck),
        .storeReq(storeReq),
        .storeAck(storeAck),
        .storeMsg(storeMsg)
    );

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    function automatic logic [regWidth-1:0] readModel(input logic [regIndexWidth-1:0] idx);
        if (idx == spIndex) begin
            return modelPriv ? modelPrivSp : modelUserSp;
        end else if (idx == pcIndex) begin
            return modelPc;
        end
        return modelGpr[idx];
    endfunction

    function automatic instrT makeInstr(input opcodeT op, input int rd, input int rs1,
                                        input int rs2, input logic [15:0] imm);
        instrT w;
        w.opcode = op;
        w.rd = regIndexWidth'(rd);
        w.rs1 = regIndexWidth'(rs1);
        w.rs2 = regIndexWidth'(rs2);
        w.imm = imm;
        return w;
    endfunction

    task automatic expectStore(input logic [regWidth-1:0] addr, input logic [regWidth-1:0] data);
        storeMsgT msg;
        msg.addr = addr;
        msg.data = data;
        expMsgs.push_back(msg);
        expNames.push_back(testName);
    endtask

    // Architectural effect of one instruction in program order
    task automatic modelExec(input instrT w);
        logic [regWidth-1:0] a;
        logic [regWidth-1:0] b;
        logic [regWidth-1:0] immExt;
        logic [regWidth-1:0] result;
        a = readModel(w.rs1);
        b = readModel(w.rs2);
        immExt = {16'h0000, w.imm};
        result = '0;
        case (w.opcode)
            opAdd:   result = a + b;
            opSub:   result = a - b;
            opAnd:   result = a & b;
            opOr:    result = a | b;
            opXor:   result = a ^ b;
            opMovi:  result = immExt;
            opStore: expectStore(a + immExt, b);
            opPush: begin
                expectStore(readModel(spIndex), a);
                if (modelPriv) begin
                    modelPrivSp = modelPrivSp - 32'd1;
                end else begin
                    modelUserSp = modelUserSp - 32'd1;
                end
            end
            opSvc: begin
                modelGpr[lrIndex] = modelPc + 32'd1;
                modelPrivSp = stackTop;
                modelPriv = 1'b1;
            end
            opEret:  modelPriv = 1'b0;
            default: ;
        endcase
        if (w.opcode inside {opAdd, opSub, opAnd, opOr, opXor, opMovi} && w.rd < spIndex) begin
            modelGpr[w.rd] = result;
        end
        modelPc = modelPc + 32'd1;
    endtask

    // Four-phase send of one word from a rising edge
    task automatic issue(input instrT w);
        modelExec(w);
        issuedCount++;
        instrReq <= 1'b1;
        instrWord <= w;
        @(posedge clock);
        while (!instrAck) @(posedge clock);
        instrReq <= 1'b0;
        @(posedge clock);
        while (instrAck) @(posedge clock);
    endtask

    task automatic runSpecialRegs();
        testName = "specialRegs";
        issue(makeInstr(opStore, 0, 0, 0, 16'h0000));   // r0 straight after reset
        issue(makeInstr(opMovi, spIndex, 0, 0, 16'h1234));
        issue(makeInstr(opMovi, pcIndex, 0, 0, 16'h0055));
        issue(makeInstr(opStore, 0, 0, spIndex, 16'h0004));
        issue(makeInstr(opStore, 0, 0, pcIndex, 16'h0008));
    endtask

    task automatic runAlu();
        testName = "aluOps";
        for (int r = 1; r < lrIndex; r++) begin
            issue(makeInstr(opMovi, r, 0, 0, 16'($urandom)));
        end
        for (int op = opAdd; op <= opXor; op++) begin
            for (int n = 0; n < 3; n++) begin
                int rd;
                rd = $urandom_range(1, 12);
                issue(makeInstr(opcodeT'(op), rd, $urandom_range(0, 12),
                                $urandom_range(0, 12), 16'h0000));
                issue(makeInstr(opStore, 0, 0, rd, 16'($urandom)));
            end
        end
    endtask

    task automatic runStackAndMode();
        testName = "stack";
        for (int r = 1; r <= 3; r++) begin
            issue(makeInstr(opPush, 0, r, 0, 16'h0000));
        end
        testName = "modeChange";
        issue(makeInstr(opSvc, 0, 0, 0, 16'h0000));
        issue(makeInstr(opStore, 0, 0, lrIndex, 16'h0010));
        issue(makeInstr(opPush, 0, 4, 0, 16'h0000));   // Fresh privileged stack
        issue(makeInstr(opPush, 0, 5, 0, 16'h0000));
        issue(makeInstr(opStore, 0, 0, spIndex, 16'h0020));
        issue(makeInstr(opEret, 0, 0, 0, 16'h0000));
        issue(makeInstr(opPush, 0, 6, 0, 16'h0000));
        issue(makeInstr(opPush, 0, 7, 0, 16'h0000));
        issue(makeInstr(opSvc, 0, 0, 0, 16'h0000));
        issue(makeInstr(opPush, 0, 8, 0, 16'h0000));   // Back at stackTop after used stack
        issue(makeInstr(opEret, 0, 0, 0, 16'h0000));
    endtask

    task automatic runBackPressure();
        testName = "backPressure";
        for (int n = 0; n < 30; n++) begin
            // Values 0 to 7 cover the ALU ops, movi, store and push
            issue(makeInstr(opcodeT'($urandom_range(0, 7)), $urandom_range(1, 15),
                            $urandom_range(0, 15), $urandom_range(0, 15), 16'($urandom)));
        end
    endtask

    initial begin
        void'($urandom(1494));
        reset = 1'b1;
        instrReq = 1'b0;
        instrWord = '0;
        modelGpr[0] = dataAreaStart;
        modelUserSp = stackTop;
        modelPrivSp = stackTop;
        modelPc = '0;
        modelPriv = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        runSpecialRegs();
        runAlu();
        runStackAndMode();
        runBackPressure();
        while (expMsgs.size() != 0 || storeReq || storeAck) @(posedge clock);
        repeat (10) @(posedge clock);
        if (!storeReq) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stopOnFailure("unexpected store request after the last expected message");
        end
    end

    // Store responder with a random ack delay
    initial begin
        int delay;
        storeMsgT expMsg;
        string expName;
        storeAck = 1'b0;
        forever begin
            @(posedge clock);
            if (storeReq && !storeAck) begin
                delay = $urandom_range(0, 5);
                repeat (delay) @(posedge clock);
                assert (expMsgs.size() > 0)
                    else stopOnFailure("store message arrived while none was expected");
                expMsg = expMsgs.pop_front();
                expName = expNames.pop_front();
                assert (storeMsg == expMsg)
                    else stopOnFailure($sformatf("error %s expected %h actual %h",
                                                 expName, expMsg, storeMsg));
                storeAck <= 1'b1;
                @(posedge clock);
                while (storeReq) @(posedge clock);
                storeAck <= 1'b0;
            end
        end
    end

    // Limit of 40 cycles per issued instruction
    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > 40 * (issuedCount + 1)) begin
            stopOnFailure("timeout, the core stopped making progress on the handshakes");
        end
    end

endmodule

/* tb.f */
src/coreTypesPkg.sv
src/instrPort.sv
src/aluUnit.sv
src/regBank.sv
src/execControl.sv
src/storePort.sv
src/execCore.sv
tb/tbClock.sv
tb/execCore_props.sv
tb/execCore_tb.sv

/* Makefile */
TOP := execCore_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
